/* flist.f */
uart_pkg.sv
uart_cfg_if.sv
uart_cfg_regs.sv
uart_cmd_seq.sv
uart_frame_tx.sv
uart_frame_rx.sv
uart_cmd_bridge.sv
uart_cmd_bridge_properties.sv
tb_uart_cmd_bridge.sv

/* tb_uart_cmd_bridge.sv */
`default_nettype none

module tb_uart_cmd_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import uart_pkg::*;

  localparam int max_tests = 32;
  localparam int fields    = 6;

  logic                      clk;
  logic                      rst_n;
  logic                      cmd_req;
  logic [cmd_width-1:0]      cmd_data;
  logic                      cmd_ack;
  logic                      cfg_req;
  logic [cfg_addr_width-1:0] cfg_addr;
  logic [div_width-1:0]      cfg_wdata;
  logic                      cfg_ack;
  logic                      tx;
  logic                      rx;
  logic [data_bits-1:0]      rd_data;
  logic                      rd_valid;
  logic                      rd_parity_err;
  logic                      rd_frame_err;

  logic [15:0] stim_mem [0:fields*max_tests-1];
  logic [15:0] kind;
  logic [15:0] fa;
  logic [15:0] fb;
  logic [15:0] fc;
  logic [15:0] fd;
  logic [15:0] fe;

  int    seed;
  int    err_count;
  int    test_count;
  int    pass_count;
  int    errs_before;
  int    t;
  bit    timed_out;
  string name;

  // line format as programmed by the tests
  int cur_div;
  bit cur_par_en;
  bit cur_par_odd;

  uart_cmd_bridge uart_cmd_bridge_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_req       (cmd_req),
    .cmd_data      (cmd_data),
    .cmd_ack       (cmd_ack),
    .cfg_req       (cfg_req),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_ack       (cfg_ack),
    .tx            (tx),
    .rx            (rx),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .rd_parity_err (rd_parity_err),
    .rd_frame_err  (rd_frame_err)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] got);
    assert (got === exp) else begin
      $display("ERROR %s: expected %0h, actual %0h", what, exp, got);
      err_count++;
    end
  endtask

  task automatic report_timeout(input string what, input string event_name);
    $display("test %s: timed out waiting for %s", what, event_name);
    err_count++;
    timed_out = 1'b1;
  endtask

  // the bit that makes the count of ones odd or even
  function automatic logic parity_of(input logic [7:0] data, input bit odd);
    parity_of = odd ? ~(^data) : ^data;
  endfunction

  task automatic wait_cfg_ack(input string what, input logic level);
    int n;
    if (timed_out) return;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cfg_ack !== level && n < 20 * cur_div + 50);
    if (cfg_ack !== level) report_timeout(what, "cfg_ack");
  endtask

  // optionally flags any start bit seen while waiting
  task automatic wait_cmd_ack(input string what, input logic level, input bit idle_check);
    int n;
    if (timed_out) return;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      assert (!idle_check || tx === 1'b1) else begin
        $display("test %s: tx left idle before cmd_ack rose", what);
        err_count++;
        idle_check = 1'b0;
      end
    end while (cmd_ack !== level && n < 2 * cur_div + 40);
    if (cmd_ack !== level) report_timeout(what, "cmd_ack");
  endtask

  // waits for the start edge and samples each bit at mid-bit
  task automatic watch_frame(input string what, input logic [7:0] exp_byte);
    int         n;
    int         i;
    logic [7:0] got;
    if (timed_out) return;
    n = 0;
    while (tx !== 1'b0 && n < 4 * cur_div + 40) begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0) begin
      report_timeout(what, "a start bit on tx");
      return;
    end
    repeat (cur_div / 2) @(negedge clk);
    check_value({what, " start bit"}, 16'h0, tx);
    for (i = 0; i < data_bits; i++) begin
      repeat (cur_div) @(negedge clk);
      got[i] = tx;
    end
    check_value({what, " data"}, exp_byte, got);
    if (cur_par_en) begin
      repeat (cur_div) @(negedge clk);
      check_value({what, " parity"}, parity_of(exp_byte, cur_par_odd), tx);
    end
    repeat (cur_div) @(negedge clk);
    check_value({what, " stop bit"}, 16'h1, tx);
  endtask

  task automatic run_cfg(input string what, input logic [15:0] addr, input logic [15:0] wdata);
    @(posedge clk);
    cfg_addr  <= addr[cfg_addr_width-1:0];
    cfg_wdata <= wdata;
    cfg_req   <= 1'b1;
    wait_cfg_ack(what, 1'b1);
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_cfg_ack(what, 1'b0);
    if (addr[0] == 1'b0) begin
      cur_div = wdata;
    end else begin
      cur_par_en  = wdata[0];
      cur_par_odd = wdata[1];
    end
  endtask

  task automatic run_cmd(input string what, input logic [15:0] cmd, input logic [15:0] frames,
                         input logic [7:0] b0, input logic [7:0] b1);
    @(posedge clk);
    cmd_data <= cmd;
    cmd_req  <= 1'b1;
    @(negedge clk);
    watch_frame({what, " frame 1"}, b0);
    // cmd_ack must wait for the end of the last stop bit
    check_value({what, " cmd_ack in frame 1"}, 16'h0, cmd_ack);
    if (frames > 1) begin
      watch_frame({what, " frame 2"}, b1);
      check_value({what, " cmd_ack in frame 2"}, 16'h0, cmd_ack);
    end
    wait_cmd_ack(what, 1'b1, 1'b1);
    @(posedge clk);
    cmd_req <= 1'b0;
    wait_cmd_ack(what, 1'b0, 1'b0);
  endtask

  task automatic drive_frame(input logic [7:0] data, input logic flip, input logic stop);
    int gap;
    int i;
    gap = $unsigned($random(seed)) % 16 + 1;
    repeat (gap) @(posedge clk);
    rx <= 1'b0;
    repeat (cur_div) @(posedge clk);
    for (i = 0; i < data_bits; i++) begin
      rx <= data[i];
      repeat (cur_div) @(posedge clk);
    end
    if (cur_par_en) begin
      rx <= parity_of(data, cur_par_odd) ^ flip;
      repeat (cur_div) @(posedge clk);
    end
    rx <= stop;
    repeat (cur_div) @(posedge clk);
    rx <= 1'b1;
  endtask

  task automatic catch_byte(input string what, input logic [7:0] data, input logic perr,
                            input logic ferr);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (rd_valid !== 1'b1 && n < 14 * cur_div + 60);
    if (rd_valid !== 1'b1) begin
      report_timeout(what, "rd_valid");
      return;
    end
    check_value({what, " rd_data"}, data, rd_data);
    check_value({what, " rd_parity_err"}, perr, rd_parity_err);
    check_value({what, " rd_frame_err"}, ferr, rd_frame_err);
  endtask

  task automatic close_test(input string what);
    test_count++;
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %s: pass", what);
    end else begin
      $display("test %s: fail", what);
    end
  endtask

  initial begin
    seed        = 60;
    err_count   = 0;
    test_count  = 0;
    pass_count  = 0;
    timed_out   = 1'b0;
    cur_div     = default_divisor;
    cur_par_en  = 1'b1;
    cur_par_odd = 1'b1;
    rst_n       = 1'b0;
    cmd_req     = 1'b0;
    cmd_data    = '0;
    cfg_req     = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    rx          = 1'b1;
    $readmemh("uart_stimulus.txt", stim_mem);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    errs_before = err_count;
    check_value("reset tx", 16'h1, tx);
    check_value("reset cmd_ack", 16'h0, cmd_ack);
    check_value("reset cfg_ack", 16'h0, cfg_ack);
    check_value("reset rd_valid", 16'h0, rd_valid);
    check_value("reset rd_parity_err", 16'h0, rd_parity_err);
    check_value("reset rd_frame_err", 16'h0, rd_frame_err);
    close_test("0 reset");

    t = 0;
    while (t < max_tests && !timed_out && !$isunknown(stim_mem[fields*t]) &&
           stim_mem[fields*t] != 16'hf) begin
      kind = stim_mem[fields*t];
      fa   = stim_mem[fields*t+1];
      fb   = stim_mem[fields*t+2];
      fc   = stim_mem[fields*t+3];
      fd   = stim_mem[fields*t+4];
      fe   = stim_mem[fields*t+5];
      errs_before = err_count;
      case (kind)
        16'h0: begin
          name = $sformatf("%0d config", t + 1);
          run_cfg(name, fa, fb);
        end
        16'h1: begin
          name = $sformatf("%0d command %04h", t + 1, fa);
          run_cmd(name, fa, fb, fc[7:0], fd[7:0]);
        end
        default: begin
          name = $sformatf("%0d receive %02h", t + 1, fa[7:0]);
          fork
            drive_frame(fa[7:0], fb[0], fc[0]);
            catch_byte(name, fa[7:0], fd[0], fe[0]);
          join
        end
      endcase
      close_test(name);
      t++;
    end

    err_count += uart_cmd_bridge_inst.uart_cmd_bridge_properties_inst.fail_count;
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             test_count, pass_count, test_count - pass_count, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_cfg_if.sv */
`default_nettype none

interface uart_cfg_if;
  import uart_pkg::*;

  logic [div_width-1:0] divisor;
  logic                 parity_en;
  logic                 parity_odd;
  // frame in flight on either line
  logic                 tx_busy;
  logic                 rx_busy;

  modport regs (output divisor, output parity_en, output parity_odd,
                input tx_busy, input rx_busy);
  modport tx (input divisor, input parity_en, input parity_odd, output tx_busy);
  modport rx (input divisor, input parity_en, input parity_odd, output rx_busy);

endinterface

`default_nettype wire

/* uart_cfg_regs.sv */
`default_nettype none

module uart_cfg_regs (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cfg_req,
  input  logic [uart_pkg::cfg_addr_width-1:0] cfg_addr,
  input  logic [uart_pkg::div_width-1:0]      cfg_wdata,
  output logic                                cfg_ack,
  uart_cfg_if.regs                            cfg
);
  import uart_pkg::*;

  logic [div_width-1:0] divisor;
  logic                 parity_en;
  logic                 parity_odd;
  logic                 line_busy;
  logic                 wr_en;

  // hold off the write until no frame is on either line
  assign line_busy = cfg.tx_busy || cfg.rx_busy;
  assign wr_en     = cfg_req && !cfg_ack && !line_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      divisor    <= default_divisor;
      parity_en  <= default_parity_en;
      parity_odd <= default_parity_odd;
      cfg_ack    <= 1'b0;
    end else begin
      if (wr_en) begin
        cfg_ack <= 1'b1;
        if (cfg_addr == cfg_addr_div) begin
          divisor <= cfg_wdata;
        end else if (cfg_addr == cfg_addr_parity) begin
          parity_en  <= cfg_wdata[parity_en_bit];
          parity_odd <= cfg_wdata[parity_odd_bit];
        end
      end else if (cfg_ack && !cfg_req) begin
        cfg_ack <= 1'b0;
      end
    end
  end

  assign cfg.divisor    = divisor;
  assign cfg.parity_en  = parity_en;
  assign cfg.parity_odd = parity_odd;

endmodule

`default_nettype wire

/* uart_cmd_bridge.sv */
`default_nettype none

module uart_cmd_bridge (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cmd_req,
  input  logic [uart_pkg::cmd_width-1:0]      cmd_data,
  output logic                                cmd_ack,
  input  logic                                cfg_req,
  input  logic [uart_pkg::cfg_addr_width-1:0] cfg_addr,
  input  logic [uart_pkg::div_width-1:0]      cfg_wdata,
  output logic                                cfg_ack,
  output logic                                tx,
  input  logic                                rx,
  output logic [uart_pkg::data_bits-1:0]      rd_data,
  output logic                                rd_valid,
  output logic                                rd_parity_err,
  output logic                                rd_frame_err
);
  import uart_pkg::*;

  logic [data_bits-1:0] byte_data;
  logic                 byte_req;
  logic                 byte_ack;

  // shared by the register block and both line engines
  uart_cfg_if cfg_bus ();

  uart_cfg_regs uart_cfg_regs_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_req   (cfg_req),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg       (cfg_bus.regs)
  );

  uart_cmd_seq uart_cmd_seq_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd_data  (cmd_data),
    .cmd_ack   (cmd_ack),
    .byte_data (byte_data),
    .byte_req  (byte_req),
    .byte_ack  (byte_ack)
  );

  uart_frame_tx uart_frame_tx_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_data (byte_data),
    .byte_req  (byte_req),
    .byte_ack  (byte_ack),
    .tx        (tx),
    .cfg       (cfg_bus.tx)
  );

  uart_frame_rx uart_frame_rx_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .rd_parity_err (rd_parity_err),
    .rd_frame_err  (rd_frame_err),
    .cfg           (cfg_bus.rx)
  );

endmodule

`default_nettype wire

/* uart_cmd_bridge_properties.sv */
`default_nettype none

module uart_cmd_bridge_properties (
  input logic clk,
  input logic rst_n,
  input logic cmd_req,
  input logic cmd_ack,
  input logic cfg_req,
  input logic cfg_ack,
  input logic rd_valid,
  input logic tx
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  assert property (@(posedge clk) disable iff (!rst_n) $rose(cmd_ack) |-> cmd_req)
    else begin
      $error("cmd_ack rose while cmd_req was low");
      fail_count++;
    end

  // four-phase release on both host ports
  assert property (@(posedge clk) disable iff (!rst_n) $fell(cmd_ack) |-> !$past(cmd_req))
    else begin
      $error("cmd_ack fell before cmd_req fell");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) $fell(cfg_ack) |-> !$past(cfg_req))
    else begin
      $error("cfg_ack fell before cfg_req fell");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) rd_valid |=> !rd_valid)
    else begin
      $error("rd_valid lasted more than one cycle");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) (!cmd_req && !cmd_ack) |-> tx)
    else begin
      $error("tx left idle with no command in progress");
      fail_count++;
    end

endmodule

bind uart_cmd_bridge uart_cmd_bridge_properties uart_cmd_bridge_properties_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_req  (cmd_req),
  .cmd_ack  (cmd_ack),
  .cfg_req  (cfg_req),
  .cfg_ack  (cfg_ack),
  .rd_valid (rd_valid),
  .tx       (tx)
);

`default_nettype wire

/* uart_cmd_seq.sv */
`default_nettype none

module uart_cmd_seq (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cmd_req,
  input  logic [uart_pkg::cmd_width-1:0] cmd_data,
  output logic                           cmd_ack,
  output logic [uart_pkg::data_bits-1:0] byte_data,
  output logic                           byte_req,
  input  logic                           byte_ack
);
  import uart_pkg::*;

  typedef enum logic [2:0] {s_idle, s_hi, s_hi_rel, s_lo, s_done} seq_state_t;

  seq_state_t           state;
  logic [cmd_width-1:0] cmd_lat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= s_idle;
      cmd_ack  <= 1'b0;
      byte_req <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (cmd_req && !cmd_ack && !byte_ack) begin
            byte_req <= 1'b1;
            state    <= s_hi;
          end
        end
        s_hi: begin
          if (byte_ack) begin
            byte_req <= 1'b0;
            // read request ends after the upper byte
            if (cmd_lat[cmd_kind_bit]) begin
              state <= s_hi_rel;
            end else begin
              cmd_ack <= 1'b1;
              state   <= s_done;
            end
          end
        end
        s_hi_rel: begin
          if (!byte_ack) begin
            byte_req <= 1'b1;
            state    <= s_lo;
          end
        end
        s_lo: begin
          if (byte_ack) begin
            byte_req <= 1'b0;
            cmd_ack  <= 1'b1;
            state    <= s_done;
          end
        end
        s_done: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // command and outgoing byte
  always_ff @(posedge clk) begin
    if (state == s_idle && cmd_req && !cmd_ack && !byte_ack) begin
      cmd_lat   <= cmd_data;
      byte_data <= cmd_data[cmd_width-1 -: data_bits];
    end else if (state == s_hi_rel && !byte_ack) begin
      byte_data <= cmd_lat[data_bits-1:0];
    end
  end

endmodule

`default_nettype wire

/* uart_frame_rx.sv */
`default_nettype none

module uart_frame_rx (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           rx,
  output logic [uart_pkg::data_bits-1:0] rd_data,
  output logic                           rd_valid,
  output logic                           rd_parity_err,
  output logic                           rd_frame_err,
  uart_cfg_if.rx                         cfg
);
  import uart_pkg::*;

  typedef enum logic [1:0] {s_idle, s_start, s_bits} rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic [div_width-1:0] bit_cnt;
  // samples taken after the start bit
  logic [3:0]           bit_idx;
  logic [3:0]           stop_idx;
  logic [data_bits-1:0] data_sh;
  logic                 par_bit;
  logic                 half_pt;
  logic                 bit_end;
  logic                 stop_pt;

  assign half_pt  = (bit_cnt == (cfg.divisor >> 1));
  assign bit_end  = (bit_cnt == cfg.divisor - div_width'(1));
  assign stop_idx = cfg.parity_en ? 4'(data_bits + 1) : 4'(data_bits);
  assign stop_pt  = (state == s_bits) && bit_end && (bit_idx == stop_idx);

  // line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= s_idle;
      cfg.rx_busy   <= 1'b0;
      bit_cnt       <= '0;
      bit_idx       <= '0;
      rd_valid      <= 1'b0;
      rd_parity_err <= 1'b0;
      rd_frame_err  <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        s_idle: begin
          if (rx_prev && !rx_sync) begin
            bit_cnt     <= '0;
            cfg.rx_busy <= 1'b1;
            state       <= s_start;
          end
        end
        s_start: begin
          if (half_pt) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            // a glitch rather than a start bit
            if (!rx_sync) begin
              state <= s_bits;
            end else begin
              cfg.rx_busy <= 1'b0;
              state       <= s_idle;
            end
          end else begin
            bit_cnt <= bit_cnt + div_width'(1);
          end
        end
        s_bits: begin
          if (bit_end) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 4'd1;
            if (stop_pt) begin
              rd_valid      <= 1'b1;
              rd_parity_err <= cfg.parity_en && (par_bit != (^data_sh ^ cfg.parity_odd));
              rd_frame_err  <= !rx_sync;
              cfg.rx_busy   <= 1'b0;
              state         <= s_idle;
            end
          end else begin
            bit_cnt <= bit_cnt + div_width'(1);
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (state == s_bits && bit_end) begin
      if (bit_idx < 4'(data_bits)) begin
        data_sh <= {rx_sync, data_sh[data_bits-1:1]};
      end else if (bit_idx == 4'(data_bits) && cfg.parity_en) begin
        par_bit <= rx_sync;
      end
    end
    if (stop_pt) begin
      rd_data <= data_sh;
    end
  end

endmodule

`default_nettype wire

/* uart_frame_tx.sv */
`default_nettype none

module uart_frame_tx (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::data_bits-1:0] byte_data,
  input  logic                           byte_req,
  output logic                           byte_ack,
  output logic                           tx,
  uart_cfg_if.tx                         cfg
);
  import uart_pkg::*;

  typedef enum logic [1:0] {s_idle, s_load, s_shift} tx_state_t;

  tx_state_t            state;
  logic [data_bits-1:0] byte_lat;
  // stop, parity and data go out from bit 0
  logic [data_bits+1:0] shreg;
  logic [div_width-1:0] bit_cnt;
  logic [3:0]           bit_idx;
  logic [3:0]           stop_idx;
  logic                 bit_end;
  logic                 par_bit;

  assign bit_end  = (bit_cnt == cfg.divisor - div_width'(1));
  // idle level fills the slot when parity is off
  assign par_bit  = cfg.parity_en ? (^byte_lat ^ cfg.parity_odd) : 1'b1;
  assign stop_idx = cfg.parity_en ? 4'(data_bits + 2) : 4'(data_bits + 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= s_idle;
      byte_ack    <= 1'b0;
      tx          <= 1'b1;
      cfg.tx_busy <= 1'b0;
      bit_cnt     <= '0;
      bit_idx     <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (byte_req && !byte_ack) begin
            cfg.tx_busy <= 1'b1;
            state       <= s_load;
          end else if (!byte_req) begin
            byte_ack <= 1'b0;
          end
        end
        s_load: begin
          // start bit
          tx      <= 1'b0;
          bit_cnt <= '0;
          bit_idx <= '0;
          state   <= s_shift;
        end
        s_shift: begin
          if (bit_end) begin
            bit_cnt <= '0;
            if (bit_idx == stop_idx) begin
              tx          <= 1'b1;
              cfg.tx_busy <= 1'b0;
              byte_ack    <= 1'b1;
              state       <= s_idle;
            end else begin
              tx      <= shreg[0];
              bit_idx <= bit_idx + 4'd1;
            end
          end else begin
            bit_cnt <= bit_cnt + div_width'(1);
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && byte_req && !byte_ack) begin
      byte_lat <= byte_data;
    end else if (state == s_load) begin
      shreg <= {1'b1, par_bit, byte_lat};
    end else if (state == s_shift && bit_end) begin
      shreg <= {1'b1, shreg[data_bits+1:1]};
    end
  end

endmodule

`default_nettype wire

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // frame format
  localparam int data_bits    = 8;
  localparam int cmd_width    = 16;
  localparam int cmd_kind_bit = 15;

  // baud divisor in clocks per bit
  localparam int div_width = 16;
  localparam logic [div_width-1:0] default_divisor = 16'd434;

  // parity after reset is enabled and odd
  localparam logic default_parity_en  = 1'b1;
  localparam logic default_parity_odd = 1'b1;

  // config register map
  localparam int cfg_addr_width = 1;
  localparam logic [cfg_addr_width-1:0] cfg_addr_div    = 1'b0;
  localparam logic [cfg_addr_width-1:0] cfg_addr_parity = 1'b1;

  // fields of the parity register
  localparam int parity_en_bit  = 0;
  localparam int parity_odd_bit = 1;

endpackage

`default_nettype wire

/* uart_stimulus.txt */
// columns, hex: kind a b c d e
// kind 0 config: a addr (0 divisor, 1 parity), b wdata
// kind 1 command: a cmd word, b frame count, c first byte, d second byte
// kind 2 receive: a data, b parity flip, c stop bit, d parity err, e frame err
// kind f ends the list
1 c35a 2 c3 5a 0
1 3a7e 1 3a 0 0
2 a5 0 1 0 0
0 0 10 0 0 0
1 8001 2 80 01 0
2 3c 0 1 0 0
2 3c 1 1 1 0
2 c7 0 0 0 1
2 5e 1 0 1 1
0 1 0 0 0 0
1 9f20 2 9f 20 0
2 81 0 1 0 0
2 81 0 0 0 1
0 1 1 0 0 0
1 7711 1 77 0 0
2 e4 1 1 1 0
0 0 7 0 0 0
2 6b 0 1 0 0
1 b2c4 2 b2 c4 0
f 0 0 0 0 0
